// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_ddr_bridge
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q -x '\*\* PASS \*\*' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== filelist.f ====
hdl/ddr_bridge_pkg.sv
hdl/cpu_req_capture.sv
hdl/mig_cmd_sequencer.sv
hdl/line_assembler.sv
hdl/ddr_bridge_top.sv
tests/clk_gen.sv
tests/mig_ui_model.sv
tests/tb_ddr_bridge.sv

// ==== hdl/cpu_req_capture.sv ====
`timescale 1ns/1ps

module cpu_req_capture (
    input  logic                     ui_clk,
    input  logic                     rst,
    input  logic                     ram_en,
    input  ddr_bridge_pkg::cpu_req_t req,
    input  logic                     op_done,
    output logic                     ram_rdy,
    output ddr_bridge_pkg::cpu_req_t held_req,
    output logic                     start
);

    // Request is only taken while idle
    logic accept;

    assign accept = ram_en && ram_rdy;

    // ------------------------------
    // Busy flag and start pulse
    // ------------------------------

    // ram_rdy drops the cycle after an accepted request
    // and comes back once the sequencer reports done
    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            ram_rdy <= 1'b1;
            start   <= 1'b0;
        end else begin
            start <= accept;
            if (accept) begin
                ram_rdy <= 1'b0;
            end else if (op_done) begin
                ram_rdy <= 1'b1;
            end
        end
    end

    // ------------------------------
    // Request register
    // ------------------------------

    // Held for the whole operation, the
    // sequencer reads address and data from here
    always_ff @(posedge ui_clk) begin
        if (accept) begin
            held_req <= req;
        end
    end

endmodule

// ==== hdl/ddr_bridge_pkg.sv ====
package ddr_bridge_pkg;

    // ------------------------------
    // Widths
    // ------------------------------

    // Processor line and controller beat
    localparam int LINE_W = 256;
    localparam int BEAT_W = 128;

    // Processor word address, 4-byte aligned
    localparam int ADDR_W = 30;

    // Controller byte address
    localparam int APP_ADDR_W = 27;

    // ------------------------------
    // Controller encodings
    // ------------------------------

    // Low address field of each beat within a line
    localparam logic [4:0] BEAT_OFS0 = 5'd0;
    localparam logic [4:0] BEAT_OFS1 = 5'd16;

    // MIG user interface command codes
    localparam logic [2:0] CMD_WRITE = 3'd0;
    localparam logic [2:0] CMD_READ  = 3'd1;

    // ------------------------------
    // Shared types
    // ------------------------------

    // One line, flat or as two beats; beat 0 sits in the low half
    typedef union packed {
        logic [LINE_W-1:0]      flat;
        logic [1:0][BEAT_W-1:0] beat;
    } ddr_line_u;

    // Processor request
    typedef struct packed {
        logic              write;
        logic [ADDR_W-1:0] addr;
        ddr_line_u         line;
    } cpu_req_t;

    // Controller command channel
    typedef struct packed {
        logic                  en;
        logic [2:0]            cmd;
        logic [APP_ADDR_W-1:0] addr;
    } app_cmd_t;

    // Controller write data channel
    typedef struct packed {
        logic              wren;
        logic [BEAT_W-1:0] data;
    } app_wdf_t;

    // Controller read return
    typedef struct packed {
        logic              valid;
        logic [BEAT_W-1:0] data;
    } app_rd_t;

endpackage

// ==== hdl/ddr_bridge_top.sv ====
`timescale 1ns/1ps

module ddr_bridge_top (
    input  logic                      ui_clk,
    input  logic                      rst,

    // Processor side
    input  logic                      ram_en,
    input  ddr_bridge_pkg::cpu_req_t  req,
    output logic                      ram_rdy,
    output ddr_bridge_pkg::ddr_line_u rd_line,
    output logic                      rd_line_valid,

    // Controller user interface
    input  logic                      init_calib_complete,
    input  logic                      app_rdy,
    input  logic                      app_wdf_rdy,
    output ddr_bridge_pkg::app_cmd_t  app_cmd,
    output ddr_bridge_pkg::app_wdf_t  app_wdf,
    input  ddr_bridge_pkg::app_rd_t   app_rd
);

    ddr_bridge_pkg::cpu_req_t held_req;
    logic                     start;
    logic                     op_done;
    logic [1:0]               beat_count;

    // ------------------------------
    // Request capture
    // ------------------------------

    cpu_req_capture u_capture (
        .ui_clk   (ui_clk),
        .rst      (rst),
        .ram_en   (ram_en),
        .req      (req),
        .op_done  (op_done),
        .ram_rdy  (ram_rdy),
        .held_req (held_req),
        .start    (start)
    );

    // ------------------------------
    // Command sequencing
    // ------------------------------

    mig_cmd_sequencer u_seq (
        .ui_clk              (ui_clk),
        .rst                 (rst),
        .start               (start),
        .held_req            (held_req),
        .init_calib_complete (init_calib_complete),
        .app_rdy             (app_rdy),
        .app_wdf_rdy         (app_wdf_rdy),
        .beat_count          (beat_count),
        .app_cmd             (app_cmd),
        .app_wdf             (app_wdf),
        .op_done             (op_done)
    );

    // Read data return
    line_assembler u_asm (
        .ui_clk        (ui_clk),
        .rst           (rst),
        .start         (start),
        .app_rd        (app_rd),
        .done          (op_done),
        .beat_count    (beat_count),
        .rd_line       (rd_line),
        .rd_line_valid (rd_line_valid)
    );

endmodule

// ==== hdl/line_assembler.sv ====
`timescale 1ns/1ps

module line_assembler (
    input  logic                      ui_clk,
    input  logic                      rst,
    input  logic                      start,
    input  ddr_bridge_pkg::app_rd_t   app_rd,
    input  logic                      done,
    output logic [1:0]                beat_count,
    output ddr_bridge_pkg::ddr_line_u rd_line,
    output logic                      rd_line_valid
);

    // Beats arrive in command order, so the count picks the half
    logic line_full;
    logic store_beat;

    assign line_full  = (beat_count == 2'd2);
    assign store_beat = app_rd.valid && !line_full;

    // ------------------------------
    // Beat counter
    // ------------------------------

    // Cleared at the start of every operation
    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            beat_count <= 2'd0;
        end else if (start) begin
            beat_count <= 2'd0;
        end else if (store_beat) begin
            beat_count <= beat_count + 2'd1;
        end
    end

    // ------------------------------
    // Line buffer
    // ------------------------------

    // Beat 0 into the low half, beat 1 into the high half
    always_ff @(posedge ui_clk) begin
        if (store_beat) begin
            rd_line.beat[beat_count[0]] <= app_rd.data;
        end
    end

    // Writes leave the count at zero, so no pulse for them
    assign rd_line_valid = done && line_full;

endmodule

// ==== hdl/mig_cmd_sequencer.sv ====
`timescale 1ns/1ps

module mig_cmd_sequencer (
    input  logic                     ui_clk,
    input  logic                     rst,
    input  logic                     start,
    input  ddr_bridge_pkg::cpu_req_t held_req,
    input  logic                     init_calib_complete,
    input  logic                     app_rdy,
    input  logic                     app_wdf_rdy,
    input  logic [1:0]               beat_count,
    output ddr_bridge_pkg::app_cmd_t app_cmd,
    output ddr_bridge_pkg::app_wdf_t app_wdf,
    output logic                     op_done
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BEAT0,
        ST_BEAT1,
        ST_RD_WAIT
    } seq_state_e;

    seq_state_e state;
    seq_state_e state_next;

    // Per-beat progress, command and data may be taken in different cycles
    logic cmd_taken;
    logic data_taken;

    logic       in_beat;
    logic       beat_sel;
    logic       is_write;
    logic       cmd_fire;
    logic       data_fire;
    logic       cmd_ok;
    logic       data_ok;
    logic       beat_done;
    logic       rd_complete;
    logic [4:0] beat_ofs;

    assign in_beat  = (state == ST_BEAT0) || (state == ST_BEAT1);
    assign beat_sel = (state == ST_BEAT1);
    assign is_write = held_req.write;
    assign beat_ofs = beat_sel ? ddr_bridge_pkg::BEAT_OFS1 : ddr_bridge_pkg::BEAT_OFS0;

    // ------------------------------
    // Controller outputs
    // ------------------------------

    // Address is the low 22 word bits plus the beat offset
    always_comb begin
        app_cmd.en   = in_beat && !cmd_taken;
        app_cmd.cmd  = is_write ? ddr_bridge_pkg::CMD_WRITE : ddr_bridge_pkg::CMD_READ;
        app_cmd.addr = {held_req.addr[21:0], beat_ofs};
    end

    // Write data goes out together with its command
    always_comb begin
        app_wdf.wren = in_beat && is_write && !data_taken;
        app_wdf.data = held_req.line.beat[beat_sel];
    end

    // ------------------------------
    // Handshake tracking
    // ------------------------------

    assign cmd_fire  = app_cmd.en && app_rdy && init_calib_complete;
    assign data_fire = app_wdf.wren && app_wdf_rdy;

    // Reads have no data half to wait for
    assign cmd_ok    = cmd_taken || cmd_fire;
    assign data_ok   = !is_write || data_taken || data_fire;
    assign beat_done = in_beat && cmd_ok && data_ok;

    assign rd_complete = (beat_count == 2'd2);

    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            cmd_taken  <= 1'b0;
            data_taken <= 1'b0;
        end else if (beat_done || !in_beat) begin
            cmd_taken  <= 1'b0;
            data_taken <= 1'b0;
        end else begin
            if (cmd_fire) begin
                cmd_taken <= 1'b1;
            end
            if (data_fire) begin
                data_taken <= 1'b1;
            end
        end
    end

    // ------------------------------
    // FSM
    // ------------------------------

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (start) begin
                    state_next = ST_BEAT0;
                end
            end
            ST_BEAT0: begin
                if (beat_done) begin
                    state_next = ST_BEAT1;
                end
            end
            ST_BEAT1: begin
                if (beat_done) begin
                    state_next = is_write ? ST_IDLE : ST_RD_WAIT;
                end
            end
            ST_RD_WAIT: begin
                // Both beats back at the assembler
                if (rd_complete) begin
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Write ends once beat 1 is fully taken, read once both beats returned
    assign op_done = (beat_sel && is_write && beat_done) ||
                     ((state == ST_RD_WAIT) && rd_complete);

endmodule

// ==== tests/bridge_trace.txt ====
# op addr line: op is W or R, addr is the 30-bit word address in hex
# line is 256 bits in hex, beat 1 first, and R lines give the line expected back
W 00000100 1111222233334444555566667777888899990000aaaabbbbccccddddeeeeffff
R 00000100 1111222233334444555566667777888899990000aaaabbbbccccddddeeeeffff
R 00000200 0000000000000000000000000000000000000000000000000000000000000000
W 00000300 0123456789abcdeffedcba98765432100f1e2d3c4b5a69788796a5b4c3d2e1f0
W 00400300 deadbeefcafef00d0badc0de12345678a5a5a5a55a5a5a5affffffff00000000
R 00000300 deadbeefcafef00d0badc0de12345678a5a5a5a55a5a5a5affffffff00000000
R 00400300 deadbeefcafef00d0badc0de12345678a5a5a5a55a5a5a5affffffff00000000
W 3fc00100 00000000000000ffff0000000000000080000000000000017ffffffffffffffe
R 00000100 00000000000000ffff0000000000000080000000000000017ffffffffffffffe
W 00001000 3141592653589793238462643383279502884197169399375105820974944592
W 00001008 2718281828459045235360287471352662497757247093699959574966967627
R 00001000 3141592653589793238462643383279502884197169399375105820974944592
R 00001008 2718281828459045235360287471352662497757247093699959574966967627
R 003fffff 0000000000000000000000000000000000000000000000000000000000000000
W 00001000 2718281828459045235360287471352662497757247093699959574966967627
R 3fc01000 2718281828459045235360287471352662497757247093699959574966967627

// ==== tests/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen (
    output logic clk
);

    // 20 ns period, first rising edge at 10 ns
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

endmodule

// ==== tests/mig_ui_model.sv ====
`timescale 1ns/1ps

module mig_ui_model (
    input  logic                     ui_clk,
    input  logic                     rst,
    input  ddr_bridge_pkg::app_cmd_t app_cmd,
    input  ddr_bridge_pkg::app_wdf_t app_wdf,
    output logic                     app_rdy,
    output logic                     app_wdf_rdy,
    output logic                     init_calib_complete,
    output ddr_bridge_pkg::app_rd_t  app_rd,
    output int                       fault_count
);

    // Sparse beat memory by controller address
    logic [ddr_bridge_pkg::BEAT_W-1:0] mem [logic [ddr_bridge_pkg::APP_ADDR_W-1:0]];

    logic [ddr_bridge_pkg::APP_ADDR_W-1:0] wr_addr_q [$];
    logic [ddr_bridge_pkg::BEAT_W-1:0]     wr_data_q [$];
    logic [ddr_bridge_pkg::APP_ADDR_W-1:0] rd_addr_q [$];
    int                                    rd_due_q  [$];

    // Unwritten beats read as zero
    function automatic logic [ddr_bridge_pkg::BEAT_W-1:0] stored_beat(
        input logic [ddr_bridge_pkg::APP_ADDR_W-1:0] a
    );
        return mem.exists(a) ? mem[a] : '0;
    endfunction

    // Runs on the falling edge and predicts the handshakes of the next rising edge
    initial begin
        int                                    cycle;
        int                                    due;
        logic                                  cmd_stalled;
        logic                                  wdf_stalled;
        logic                                  rdy_next;
        logic                                  wdf_rdy_next;
        logic                                  calib_next;
        ddr_bridge_pkg::app_cmd_t              last_cmd;
        ddr_bridge_pkg::app_wdf_t              last_wdf;
        logic [ddr_bridge_pkg::APP_ADDR_W-1:0] a;
        void'($urandom(53));
        cycle = 0;
        cmd_stalled = 1'b0;
        wdf_stalled = 1'b0;
        fault_count = 0;
        app_rdy <= 1'b0;
        app_wdf_rdy <= 1'b0;
        init_calib_complete <= 1'b0;
        app_rd <= '0;
        forever begin
            @(negedge ui_clk);
            cycle++;
            // Ready levels that the bridge sees at the next rising edge
            rdy_next = ($urandom % 4) != 0;
            wdf_rdy_next = ($urandom % 4) != 0;
            calib_next = (cycle >= 10);
            if (rst) begin
                // Held command and data must not move under back-pressure
                if (cmd_stalled && app_cmd !== last_cmd) begin
                    fault_count++;
                    $display("Command changed at %0t before the controller took it", $time);
                end
                if (wdf_stalled && app_wdf !== last_wdf) begin
                    fault_count++;
                    $display("Write data changed at %0t before the controller took it", $time);
                end
                if (app_cmd.en && rdy_next && calib_next) begin
                    if (app_cmd.cmd == ddr_bridge_pkg::CMD_WRITE) begin
                        wr_addr_q.push_back(app_cmd.addr);
                    end else begin
                        // In-order return 2 to 5 cycles after the command
                        due = cycle + 2 + int'($urandom % 4);
                        if (rd_due_q.size() > 0 && due <= rd_due_q[$]) begin
                            due = rd_due_q[$] + 1;
                        end
                        rd_addr_q.push_back(app_cmd.addr);
                        rd_due_q.push_back(due);
                    end
                end
                if (app_wdf.wren && wdf_rdy_next) begin
                    wr_data_q.push_back(app_wdf.data);
                end
                while (wr_addr_q.size() > 0 && wr_data_q.size() > 0) begin
                    mem[wr_addr_q.pop_front()] = wr_data_q.pop_front();
                end
                cmd_stalled = app_cmd.en && !(rdy_next && calib_next);
                wdf_stalled = app_wdf.wren && !wdf_rdy_next;
                last_cmd = app_cmd;
                last_wdf = app_wdf;
            end
            // Read return seen at the next rising edge
            app_rd <= '0;
            if (rd_due_q.size() > 0 && rd_due_q[0] <= cycle) begin
                a = rd_addr_q.pop_front();
                void'(rd_due_q.pop_front());
                app_rd.valid <= 1'b1;
                app_rd.data <= stored_beat(a);
            end
            init_calib_complete <= calib_next;
            app_rdy <= rdy_next;
            app_wdf_rdy <= wdf_rdy_next;
        end
    end

endmodule

// ==== tests/tb_ddr_bridge.sv ====
`timescale 1ns/1ps

module tb_ddr_bridge;

    logic                      ui_clk;
    logic                      rst;
    logic                      ram_en;
    ddr_bridge_pkg::cpu_req_t  req;
    logic                      ram_rdy;
    ddr_bridge_pkg::ddr_line_u rd_line;
    logic                      rd_line_valid;
    logic                      init_calib_complete;
    logic                      app_rdy;
    logic                      app_wdf_rdy;
    ddr_bridge_pkg::app_cmd_t  app_cmd;
    ddr_bridge_pkg::app_wdf_t  app_wdf;
    ddr_bridge_pkg::app_rd_t   app_rd;
    int                        fault_count;

    // Trace contents with one entry per operation
    logic                              op_write [$];
    logic [ddr_bridge_pkg::ADDR_W-1:0] op_addr  [$];
    logic [ddr_bridge_pkg::LINE_W-1:0] op_line  [$];

    int trace_len = 0;
    int errors = 0;
    int checks = 0;

    clk_gen u_clk (.clk(ui_clk));

    mig_ui_model u_mig (
        .ui_clk              (ui_clk),
        .rst                 (rst),
        .app_cmd             (app_cmd),
        .app_wdf             (app_wdf),
        .app_rdy             (app_rdy),
        .app_wdf_rdy         (app_wdf_rdy),
        .init_calib_complete (init_calib_complete),
        .app_rd              (app_rd),
        .fault_count         (fault_count)
    );

    ddr_bridge_top dut0 (
        .ui_clk              (ui_clk),
        .rst                 (rst),
        .ram_en              (ram_en),
        .req                 (req),
        .ram_rdy             (ram_rdy),
        .rd_line             (rd_line),
        .rd_line_valid       (rd_line_valid),
        .init_calib_complete (init_calib_complete),
        .app_rdy             (app_rdy),
        .app_wdf_rdy         (app_wdf_rdy),
        .app_cmd             (app_cmd),
        .app_wdf             (app_wdf),
        .app_rd              (app_rd)
    );

    // ------------------------------
    // Trace file
    // ------------------------------

    task automatic load_trace();
        int                                fd;
        int                                n;
        string                             text;
        logic [7:0]                        op;
        logic [ddr_bridge_pkg::ADDR_W-1:0] a;
        logic [ddr_bridge_pkg::LINE_W-1:0] l;
        fd = $fopen("tests/bridge_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the trace file tests/bridge_trace.txt");
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(text, fd);
            if (n > 0) begin
                n = $sscanf(text, "%s %h %h", op, a, l);
                // Comment lines stop after the first token
                if (n == 3 && (op == "W" || op == "R")) begin
                    op_write.push_back(op == "W");
                    op_addr.push_back(a);
                    op_line.push_back(l);
                end
            end
        end
        $fclose(fd);
        trace_len = op_write.size();
    endtask

    // ------------------------------
    // Controller memory contents
    // ------------------------------

    task automatic check_stored_beat(
        input string                                 name,
        input int                                    beat,
        input logic [ddr_bridge_pkg::APP_ADDR_W-1:0] a,
        input logic [ddr_bridge_pkg::BEAT_W-1:0]     expected
    );
        logic [ddr_bridge_pkg::BEAT_W-1:0] actual;
        actual = u_mig.stored_beat(a);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s beat %0d: expected %h, actual %h",
                     name, beat, expected, actual);
        end
    endtask

    // ------------------------------
    // One processor request
    // ------------------------------

    // Called on a falling edge with the bridge idle
    task automatic run_op(input int idx);
        string                     name;
        int                        pulses;
        ddr_bridge_pkg::ddr_line_u got;
        name = $sformatf("%s_%0d_%h", op_write[idx] ? "write" : "read", idx, op_addr[idx]);
        pulses = 0;
        got = '0;
        if (!ram_rdy) begin
            errors++;
            $display("ram_rdy is low before %s is issued", name);
        end
        ram_en = 1'b1;
        req.write = op_write[idx];
        req.addr = op_addr[idx];
        req.line.flat = op_write[idx] ? op_line[idx] : '0;
        @(negedge ui_clk);
        ram_en = 1'b0;
        while (!ram_rdy) begin
            if (rd_line_valid) begin
                pulses++;
                got = rd_line;
            end
            @(negedge ui_clk);
        end
        checks++;
        if (!init_calib_complete) begin
            errors++;
            $display("%s finished before calibration completed", name);
        end
        if (rd_line_valid) begin
            errors++;
            $display("rd_line_valid is high with ram_rdy already high after %s", name);
        end
        if (op_write[idx] && pulses != 0) begin
            errors++;
            $display("Mismatch %s rd_line_valid pulses: expected 0, actual %0d", name, pulses);
        end else if (!op_write[idx] && pulses != 1) begin
            errors++;
            $display("Mismatch %s rd_line_valid pulses: expected 1, actual %0d", name, pulses);
        end else if (!op_write[idx] && got.flat !== op_line[idx]) begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h", name, op_line[idx], got.flat);
        end
        // Low half at byte offset 0, high half at byte offset 16
        if (op_write[idx]) begin
            check_stored_beat(name, 0, {op_addr[idx][21:0], 5'd0}, op_line[idx][127:0]);
            check_stored_beat(name, 1, {op_addr[idx][21:0], 5'd16}, op_line[idx][255:128]);
        end
    endtask

    // Watchdog allows 40 cycles per trace operation
    initial begin
        wait (trace_len > 0);
        repeat (trace_len * 40) @(posedge ui_clk);
        $display("Timeout: trace not finished after %0d cycles", trace_len * 40);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        int i;
        rst = 1'b0;
        ram_en = 1'b0;
        req = '0;
        load_trace();
        if (trace_len == 0) begin
            errors++;
            $display("No operations could be read from the trace file");
        end
        repeat (4) @(posedge ui_clk);
        @(negedge ui_clk);
        rst = 1'b1;
        @(negedge ui_clk);
        for (i = 0; i < trace_len; i++) begin
            run_op(i);
        end
        $display("Operations %0d, checks %0d, errors %0d, model errors %0d",
                 trace_len, checks, errors, fault_count);
        if (errors == 0 && fault_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
